// ==== source/spi_consts.svh ====
// Frame width and sck half period are fixed at build time; a half period of at least 1 clk
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Bits exchanged in each frame, MSB first
`define SPI_WORD_BITS 16

// Clk cycles per sck half period
// Whole frame takes 32 half periods plus two cycles
`define SPI_HALF_PERIOD 2

`endif

// ==== source/spi_pkg.sv ====
// Word type follows SPI_WORD_BITS; the bit counter must hold the full word count
`include "spi_consts.svh"

package spi_pkg;

    // One SPI frame, transmit or receive
    typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

    // Counts sck periods within a frame
    typedef logic [$clog2(`SPI_WORD_BITS + 1)-1:0] bit_count_t;

    // Frame sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } xfer_state_e;

endpackage

// ==== source/spi_link_if.sv ====
// Internal link between sequencer and datapath; all strobes are one clk wide
`timescale 1ns/10ps

interface spi_link_if;
    import spi_pkg::*;

    // Frame active, sck and shifting enabled
    logic run;
    // Copy transmit word into shift register
    logic load;
    // One clk ahead of the sck level change
    logic sck_rise;
    logic sck_fall;
    // Live shift register contents
    spi_word_t rx_word;

    modport ctrl (
        output run,
        output load,
        input  sck_rise,
        input  sck_fall,
        input  rx_word
    );

    modport clkgen (
        input  run,
        output sck_rise,
        output sck_fall
    );

    modport shifter (
        input  load,
        input  sck_rise,
        input  sck_fall,
        output rx_word
    );

endinterface

// ==== source/spi_clock_gen.sv ====
// Mode 0 only: sck idles low, first edge is a rise HALF_PERIOD clks after run
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_clock_gen #(
    parameter int HALF_PERIOD = `SPI_HALF_PERIOD
) (
    input  logic       clk,
    input  logic       rst,
    spi_link_if.clkgen link,
    output logic       sck
);

    // At least one bit of counter even for a half period of 1
    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             half_end;

    // Last clk of the current half period
    assign half_end = link.run && (div_cnt == CNT_W'(HALF_PERIOD - 1));

    // Strobes lead the sck level by one clk
    assign link.sck_rise = half_end && !sck;
    assign link.sck_fall = half_end && sck;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (!link.run) begin
            // Parked between frames
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (half_end) begin
            div_cnt <= '0;
            sck     <= !sck;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // The sequencer drops run exactly on the last fall, so sck is never left high
    assert property (@(posedge clk) disable iff (rst)
        !link.run |-> !sck)
        else $error("sck high while no frame is running");

endmodule

// ==== source/spi_shift_reg.sv ====
// MSB first; miso is sampled at the rising sck edge and shifted in at the next fall
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_shift_reg (
    input  logic               clk,
    input  logic               rst,
    input  spi_pkg::spi_word_t data_in,
    input  logic               miso,
    spi_link_if.shifter        link,
    output logic               mosi
);
    import spi_pkg::*;

    spi_word_t shift_word;
    // Holds miso between the rise and the following fall
    logic      miso_bit;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_word <= '0;
        end else if (link.load) begin
            shift_word <= data_in;
        end else if (link.sck_fall) begin
            // Drop the sent bit, append the one just sampled
            shift_word <= {shift_word[`SPI_WORD_BITS-2:0], miso_bit};
        end
    end

    always_ff @(posedge clk) begin
        if (link.sck_rise) begin
            miso_bit <= miso;
        end
    end

    assign mosi         = shift_word[`SPI_WORD_BITS-1];
    assign link.rx_word = shift_word;

    // Loads happen only in IDLE, where the clock generator is parked
    assert property (@(posedge clk) disable iff (rst)
        link.load |-> !(link.sck_rise || link.sck_fall))
        else $error("load collided with an sck strobe");

endmodule

// ==== source/spi_xfer_ctrl.sv ====
// begin_xfer is dropped outside IDLE; data_out holds until the next completed frame
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_xfer_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               begin_xfer,
    spi_link_if.ctrl           link,
    output logic               ss_n,
    output logic               xfer_done,
    output spi_pkg::spi_word_t data_out
);
    import spi_pkg::*;

    xfer_state_e state;
    bit_count_t  bit_cnt;
    spi_word_t   data_out_q;
    logic        accept;
    logic        last_fall;

    // New frame only from IDLE
    assign accept = (state == IDLE) && begin_xfer;

    // Falling edge that closes the 16th sck period
    assign last_fall = (state == RUN) && link.sck_fall &&
                       (bit_cnt == bit_count_t'(`SPI_WORD_BITS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (accept) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (last_fall) begin
                        state <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Periods completed in the current frame
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (accept) begin
            bit_cnt <= '0;
        end else if ((state == RUN) && link.sck_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out_q <= '0;
        end else if (state == DONE) begin
            data_out_q <= link.rx_word;
        end
    end

    assign link.load = accept;
    assign link.run  = (state == RUN);
    assign ss_n      = (state != RUN);
    assign xfer_done = (state == DONE);

    // Last shift has landed by DONE, so pass the live word through
    assign data_out = xfer_done ? link.rx_word : data_out_q;

    assert property (@(posedge clk) disable iff (rst)
        xfer_done |=> !xfer_done)
        else $error("xfer_done held for more than one cycle");

    // Slave select opens only after a load and closes only with completion
    assert property (@(posedge clk) disable iff (rst)
        $fell(ss_n) |-> $past(link.load))
        else $error("ss_n fell without a load");

    assert property (@(posedge clk) disable iff (rst)
        $rose(ss_n) |-> xfer_done)
        else $error("ss_n rose without xfer_done");

endmodule

// ==== source/spi_master_top.sv ====
// Single slave, mode 0, fixed 16-bit word; sck runs at clk / (2 * SPI_HALF_PERIOD)
`timescale 1ns/10ps

module spi_master_top (
    input  logic               clk,
    input  logic               rst,
    input  spi_pkg::spi_word_t data_in,
    input  logic               begin_xfer,
    output spi_pkg::spi_word_t data_out,
    output logic               xfer_done,
    // SPI bus
    output logic               sck,
    output logic               ss_n,
    output logic               mosi,
    input  logic               miso
);

    spi_link_if link ();

    // Frame sequencing, slave select and result register
    spi_xfer_ctrl i_spi_xfer_ctrl (
        .clk        (clk),
        .rst        (rst),
        .begin_xfer (begin_xfer),
        .link       (link.ctrl),
        .ss_n       (ss_n),
        .xfer_done  (xfer_done),
        .data_out   (data_out)
    );

    spi_clock_gen i_spi_clock_gen (
        .clk  (clk),
        .rst  (rst),
        .link (link.clkgen),
        .sck  (sck)
    );

    // Transmit and receive share one register
    spi_shift_reg i_spi_shift_reg (
        .clk     (clk),
        .rst     (rst),
        .data_in (data_in),
        .miso    (miso),
        .link    (link.shifter),
        .mosi    (mosi)
    );

endmodule

// ==== verification/spi_master_tb.sv ====
// Mode 0 slave model with one fixed 16-bit word per frame; frames never overlap in the stimulus
`timescale 1ns/10ps
`include "spi_consts.svh"

module spi_master_tb;
    import spi_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_FRAMES = 8;
    localparam int CORNER_FRAMES = 4;
    // Random frames, one frame with a stray start, then the corner frames
    localparam int NUM_FRAMES     = RANDOM_FRAMES + 1 + CORNER_FRAMES;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (32 * `SPI_HALF_PERIOD + 10) + 100;

    logic      clk;
    logic      rst;
    spi_word_t data_in;
    logic      begin_xfer;
    spi_word_t data_out;
    logic      xfer_done;
    logic      sck;
    logic      ss_n;
    logic      mosi;
    logic      miso;

    // Slave side of the bus
    spi_word_t  slave_word;
    spi_word_t  slave_tx;
    spi_word_t  slave_rx;
    bit_count_t rise_cnt;

    // Expected results, one entry per accepted start
    spi_word_t exp_rx_q[$];
    spi_word_t exp_tx_q[$];

    // Last word data_out must show between completions
    spi_word_t   held_word   = '0;
    int          done_cnt    = 0;
    int          started_cnt = 0;
    int          cycle_cnt   = 0;
    logic [15:0] lfsr_state;
    string       test_name;

    spi_master_top i_spi_master_top (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .begin_xfer (begin_xfer),
        .data_out   (data_out),
        .xfer_done  (xfer_done),
        .sck        (sck),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .miso       (miso)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input spi_word_t expected,
                              input spi_word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            abort_run("A received word does not match");
        end
    endtask

    task automatic check_count(input string name, input bit_count_t expected,
                               input bit_count_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            abort_run("A count does not match");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            abort_run("A control line has the wrong level");
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_word(output spi_word_t word);
        word = '0;
        for (int i = 0; i < `SPI_WORD_BITS; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word = {word[`SPI_WORD_BITS-2:0], lfsr_state[0]};
        end
    endtask

    // Word seen at the far end after one MSB-first serial exchange
    function automatic spi_word_t expected_exchange(input spi_word_t sent);
        spi_word_t received;
        received = '0;
        for (int i = `SPI_WORD_BITS - 1; i >= 0; i--) begin
            received = {received[`SPI_WORD_BITS-2:0], sent[i]};
        end
        return received;
    endfunction

    // Slave model, mode 0
    always @(negedge ss_n) begin
        slave_tx = slave_word;
        slave_rx = '0;
        rise_cnt = '0;
        miso = slave_tx[`SPI_WORD_BITS-1];
    end

    always @(posedge sck) begin
        if (!ss_n) begin
            slave_rx = {slave_rx[`SPI_WORD_BITS-2:0], mosi};
            rise_cnt = rise_cnt + bit_count_t'(1);
        end
    end

    always @(negedge sck) begin
        if (!ss_n) begin
            slave_tx = {slave_tx[`SPI_WORD_BITS-2:0], 1'b0};
            miso = slave_tx[`SPI_WORD_BITS-1];
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the frames did not complete in time");
        end
    end

    // Compare at mid cycle, where all DUT outputs have settled
    always @(negedge clk) begin
        if (rst) begin
            // Nothing to compare during reset
        end else if (ss_n && sck) begin
            abort_run("sck is high while ss_n is high");
        end else if (xfer_done && (exp_rx_q.size() == 0)) begin
            abort_run("xfer_done pulsed without an accepted start");
        end else if (xfer_done) begin
            held_word = exp_rx_q.pop_front();
            check_word({test_name, " data_out"}, held_word, data_out);
            check_word({test_name, " mosi capture"}, exp_tx_q.pop_front(), slave_rx);
            check_count({test_name, " sck rises"}, bit_count_t'(`SPI_WORD_BITS), rise_cnt);
            done_cnt++;
        end else begin
            // data_out keeps the last received word until the next completion
            check_word({test_name, " data_out hold"}, held_word, data_out);
        end
    end

    task automatic start_frame(input spi_word_t tx_word, input spi_word_t slave_data);
        @(posedge clk);
        #DRIVE_DELAY;
        data_in    = tx_word;
        slave_word = slave_data;
        begin_xfer = 1'b1;
        exp_tx_q.push_back(expected_exchange(tx_word));
        exp_rx_q.push_back(expected_exchange(slave_data));
        started_cnt++;
        @(posedge clk);
        #DRIVE_DELAY begin_xfer = 1'b0;
    endtask

    task automatic wait_frame_done(input int target);
        while (done_cnt < target) begin
            @(posedge clk);
        end
    endtask

    task automatic run_frame(input spi_word_t tx_word, input spi_word_t slave_data);
        int target;
        target = started_cnt + 1;
        start_frame(tx_word, slave_data);
        wait_frame_done(target);
    endtask

    initial begin
        spi_word_t tx_word;
        spi_word_t rx_word;
        spi_word_t corner [CORNER_FRAMES];
        int        target;

        rst        = 1'b1;
        data_in    = '0;
        begin_xfer = 1'b0;
        miso       = 1'b0;
        slave_word = '0;
        lfsr_state = 16'd71;
        test_name  = "reset";
        corner[0]  = 16'h0000;
        corner[1]  = 16'hFFFF;
        corner[2]  = 16'h8000;
        corner[3]  = 16'h0001;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        @(negedge clk);
        check_level("reset ss_n", 1'b1, ss_n);
        check_level("reset sck", 1'b0, sck);
        check_level("reset xfer_done", 1'b0, xfer_done);
        check_level("reset mosi", 1'b0, mosi);
        check_word("reset data_out", '0, data_out);

        test_name = "random";
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            random_word(tx_word);
            random_word(rx_word);
            run_frame(tx_word, rx_word);
        end

        // Second start well inside the frame, with different data
        test_name = "stray start";
        random_word(tx_word);
        random_word(rx_word);
        target = started_cnt + 1;
        start_frame(tx_word, rx_word);
        repeat (8 * `SPI_HALF_PERIOD) @(posedge clk);
        #DRIVE_DELAY;
        data_in    = ~tx_word;
        begin_xfer = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY begin_xfer = 1'b0;
        wait_frame_done(target);
        repeat (2 * `SPI_HALF_PERIOD) @(posedge clk);
        @(negedge clk);
        check_level("stray start ss_n", 1'b1, ss_n);

        test_name = "corner";
        for (int i = 0; i < CORNER_FRAMES; i++) begin
            run_frame(corner[i], corner[CORNER_FRAMES-1-i]);
        end

        // Leave room for a spurious completion to show up
        repeat (4 * `SPI_HALF_PERIOD) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/spi_pkg.sv
source/spi_link_if.sv
source/spi_clock_gen.sv
source/spi_shift_reg.sv
source/spi_xfer_ctrl.sv
source/spi_master_top.sv
verification/spi_master_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module spi_master_tb \
    -o spi_master_sim \
    && ./obj_dir/spi_master_sim \
    && echo "spi_master_tb: simulation passed" \
    || { echo "spi_master_tb: simulation failed"; exit 1; }
